// ==== tb.f ====
common/ldst_pkg.sv
ldst/ldst_pop.sv
ldst/ldst_control.sv
design/ldst_sequencer.sv
design/ldst_addr_gen.sv
design/ldst_unit.sv
tests/ldst_checker.sv
tests/tb_ldst.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing -Wno-fatal
TOP       := tb_ldst
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_ldst.sv ====
`timescale 1ns/1ps

module tb_ldst;
	import ldst_pkg::*;

	localparam int num_requests = 200;
	localparam int reset_cycles = 4;
	localparam int max_cycles   = reset_cycles + num_requests * 70;
	localparam logic [31:0] seed = 32'd28681;

	logic        clk = 1'b0;
	logic        rst;
	logic        issue;
	ldst_req_t   req;
	word         rd_value;
	logic        mem_ready = 1'b0;
	word         mem_rdata = '0;
	logic        mem_start;
	mem_req_t    mem_req;
	logic        load_we;
	load_wr_t    load_wr;
	logic        base_we;
	word         base_value;
	logic        busy;
	int          errors;
	int          transfers;
	int          ignored;
	int          outstanding;
	int          requests = 0;
	int          cycles = 0;
	int          total_errors;
	logic [31:0] req_state = seed;
	logic [31:0] mem_state = seed ^ 32'h9E37_79B9;
	logic        mem_waiting = 1'b0;
	logic [1:0]  mem_delay = '0;

	ldst_unit u_dut (.*);

	ldst_checker u_checker (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic ldst_req_t random_request();
		ldst_req_t   r;
		logic [31:0] kind;
		req_state = xorshift(req_state);
		r.base = 32'h0010_0000 + (req_state & 32'h000F_FFFC); // Word aligned, far from wrap.
		req_state = xorshift(req_state);
		kind = req_state;
		case (kind[2:0])
			3'd0:    r.regs = 16'hFFFF;
			3'd1:    r.regs = '0;
			3'd2:    r.regs = 16'h0001 << kind[7:4];
			default: r.regs = kind[31:16];
		endcase
		r.load = kind[8];
		r.increment = kind[9];
		r.pre_indexed = kind[10];
		r.writeback = kind[11];
		return r;
	endfunction

	// ==============================
	// Register file and memory
	// ==============================
	assign rd_value = 32'hA000_0000 + (word'(mem_req.reg_sel) << 4);

	always @(negedge clk) begin
		mem_ready = 1'b0;
		if (mem_start) begin
			if (!mem_waiting) begin
				mem_state = xorshift(mem_state);
				mem_delay = mem_state[1:0]; // 0 to 3 cycles.
				mem_waiting = 1'b1;
			end
			if (mem_delay == 2'd0) begin
				mem_ready = 1'b1;
				mem_rdata = word'({mem_req.addr, 2'b00}) * 32'd3;
				mem_waiting = 1'b0;
			end else begin
				mem_delay = mem_delay - 2'd1;
			end
		end
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		rst = 1'b1;
		issue = 1'b0;
		req = '0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < num_requests; i++) begin
			@(negedge clk);
			req = random_request();
			issue = 1'b1;
			requests++;
			@(negedge clk);
			issue = 1'b0;
			req_state = xorshift(req_state);
			if (busy && req_state[0]) begin
				req = random_request(); // Arrives while busy.
				issue = 1'b1;
				@(negedge clk);
				issue = 1'b0;
			end
			while (busy)
				@(negedge clk);
		end
		repeat (3) @(negedge clk);
		total_errors = errors;
		if (outstanding != 0) begin
			$display("%0d expected transfers never happened", outstanding);
			total_errors++;
		end
		$display("requests %0d, transfers %0d, ignored issues %0d, errors %0d",
			requests, transfers, ignored, total_errors);
		if (total_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

// ==== tests/ldst_checker.sv ====
`timescale 1ns/1ps

module ldst_checker (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  ldst_pkg::ldst_req_t req,
	input  logic                busy,
	input  logic                mem_start,
	input  ldst_pkg::mem_req_t  mem_req,
	input  logic                mem_ready,
	input  logic                load_we,
	input  ldst_pkg::load_wr_t  load_wr,
	input  logic                base_we,
	input  ldst_pkg::word       base_value,
	output int                  errors,
	output int                  transfers,
	output int                  ignored,
	output int                  outstanding
);
	import ldst_pkg::*;

	typedef struct packed {
		ptr     addr;
		logic   write;
		word    data;      // Store data, or load value for loads.
		reg_num rsel;
		logic   last;
		logic   wb;
		word    wb_value;
	} expect_t;

	expect_t  exp_q[$];
	expect_t  cur;
	expect_t  done_exp;
	mem_req_t held;
	logic     held_valid;
	logic     load_due;
	logic     base_due;
	logic     active;
	logic     accepted;

	// ==============================
	// Reference model
	// ==============================
	function automatic expect_t expected_transfer(ldst_req_t r, int k);
		expect_t e;
		int      n;
		int      seen;
		int      j;
		word     first;
		word     addr;
		e = '0;
		n = $countones(r.regs);
		seen = 0;
		for (int i = 0; i < num_regs; i++) begin
			j = r.increment ? i : num_regs - 1 - i; // Walk in pop order.
			if (r.regs[j]) begin
				if (seen == k)
					e.rsel = reg_num'(j);
				seen++;
			end
		end
		first = r.base;
		if (r.pre_indexed)
			first = r.increment ? r.base + 32'd4 : r.base - 32'd4;
		addr = r.increment ? first + 32'(4 * k) : first - 32'(4 * k);
		e.addr = addr[31:2];
		e.write = !r.load;
		e.data = r.load ? addr * 32'd3 : 32'hA000_0000 + (word'(e.rsel) << 4);
		e.last = k == n - 1;
		e.wb = r.writeback;
		e.wb_value = r.increment ? r.base + 32'(4 * n) : r.base - 32'(4 * n);
		return e;
	endfunction

	task automatic report_mismatch(string name, logic [127:0] expv, logic [127:0] got);
		errors++;
		$display("ERR %0t %s expected %0h got %0h", $time, name, expv, got);
	endtask

	task automatic report_failure(string what);
		errors++;
		$display("At %0t: %s", $time, what);
	endtask

	// ==============================
	// Compare on every rising edge
	// ==============================
	always @(posedge clk) begin
		if (rst) begin
			exp_q.delete();
			errors = 0;
			transfers = 0;
			ignored = 0;
			held_valid = 1'b0;
			load_due = 1'b0;
			base_due = 1'b0;
			active = 1'b0;
			accepted = 1'b0;
			done_exp = '0;
		end else begin
			if (mem_start !== active)
				report_mismatch("mem_start", active, mem_start);
			if (busy !== active)
				report_mismatch("busy", active, busy);
			if (load_we !== load_due)
				report_mismatch("load_we", load_due, load_we);
			if (base_we !== base_due)
				report_mismatch("base_we", base_due, base_we);
			if (load_we && load_due) begin
				if (load_wr.dst !== done_exp.rsel)
					report_mismatch("load_wr.dst", done_exp.rsel, load_wr.dst);
				if (load_wr.value !== done_exp.data)
					report_mismatch("load_wr.value", done_exp.data, load_wr.value);
			end
			if (base_we && base_due && base_value !== done_exp.wb_value)
				report_mismatch("base_value", done_exp.wb_value, base_value);
			load_due = 1'b0;
			base_due = 1'b0;
			accepted = issue && !active && req.regs != '0; // Idle as seen before this edge.

			if (mem_start) begin
				if (held_valid && mem_req !== held)
					report_mismatch("mem_req", held, mem_req); // Changed while waiting.
				held = mem_req;
				held_valid = 1'b1;
			end

			if (mem_start && mem_ready) begin
				held_valid = 1'b0;
				transfers++;
				if (exp_q.size() == 0) begin
					report_failure("memory transfer completed with no transfer expected");
				end else begin
					cur = exp_q.pop_front();
					if (mem_req.addr !== cur.addr)
						report_mismatch("mem_req.addr", cur.addr, mem_req.addr);
					if (mem_req.write !== cur.write)
						report_mismatch("mem_req.write", cur.write, mem_req.write);
					if (mem_req.reg_sel !== cur.rsel)
						report_mismatch("mem_req.reg_sel", cur.rsel, mem_req.reg_sel);
					if (cur.write && mem_req.data !== cur.data)
						report_mismatch("mem_req.data", cur.data, mem_req.data);
					load_due = !cur.write;
					base_due = cur.last && cur.wb;
					if (cur.last)
						active = 1'b0;
					done_exp = cur;
				end
			end

			if (accepted) begin
				for (int k = 0; k < $countones(req.regs); k++)
					exp_q.push_back(expected_transfer(req, k));
				active = 1'b1;
			end else if (issue) begin
				ignored++; // Empty list or already busy.
			end
		end
		outstanding = exp_q.size();
	end

endmodule

// ==== design/ldst_unit.sv ====
`timescale 1ns/1ps

module ldst_unit (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  ldst_pkg::ldst_req_t req,
	input  ldst_pkg::word       rd_value,
	input  logic                mem_ready,
	input  ldst_pkg::word       mem_rdata,
	output logic                mem_start,
	output ldst_pkg::mem_req_t  mem_req,
	output logic                load_we,
	output ldst_pkg::load_wr_t  load_wr,
	output logic                base_we,
	output ldst_pkg::word       base_value,
	output logic                busy
);
	import ldst_pkg::*;

	ctrl_cycle cycle;
	ctrl_cycle next_cycle;
	logic      last_transfer;
	logic      advance;
	ptr        cur_addr;
	word       base_calc;

	ldst_sequencer u_sequencer (
		.clk           (clk),
		.rst           (rst),
		.issue         (issue),
		.regs          (req.regs),
		.last_transfer (last_transfer),
		.cycle         (cycle),
		.next_cycle    (next_cycle),
		.busy          (busy)
	);

	ldst_addr_gen u_addr_gen (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.cycle      (cycle),
		.next_cycle (next_cycle),
		.advance    (advance),
		.cur_addr   (cur_addr),
		.base_value (base_calc)
	);

	ldst_control u_control (
		.clk            (clk),
		.rst            (rst),
		.issue          (issue),
		.req            (req),
		.cycle          (cycle),
		.next_cycle     (next_cycle),
		.cur_addr       (cur_addr),
		.base_value     (base_calc),
		.rd_value       (rd_value),
		.mem_ready      (mem_ready),
		.mem_rdata      (mem_rdata),
		.mem_start      (mem_start),
		.mem_req        (mem_req),
		.advance        (advance),
		.last_transfer  (last_transfer),
		.load_we        (load_we),
		.load_wr        (load_wr),
		.base_we        (base_we),
		.base_value_out (base_value)
	);

endmodule

// ==== design/ldst_addr_gen.sv ====
`timescale 1ns/1ps

module ldst_addr_gen (
	input  logic                clk,
	input  logic                rst,
	input  ldst_pkg::ldst_req_t req,
	input  ldst_pkg::ctrl_cycle cycle,
	input  ldst_pkg::ctrl_cycle next_cycle,
	input  logic                advance,
	output ldst_pkg::ptr        cur_addr,
	output ldst_pkg::word       base_value
);
	import ldst_pkg::*;

	logic     entry;
	logic     increment;
	reg_count count;
	word      span;
	word      first_addr;

	assign entry = cycle == ISSUE && next_cycle == TRANSFER;

	always_comb begin
		count = '0;
		for (int i = 0; i < num_regs; i++)
			count = count + reg_count'(req.regs[i]);
	end

	assign span = word'(count) * word_bytes; // Total bytes moved.

	always_comb begin
		first_addr = req.base;
		if (req.pre_indexed)
			first_addr = req.increment ? req.base + word_bytes : req.base - word_bytes;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cur_addr   <= '0;
			base_value <= '0;
			increment  <= 1'b0;
		end else if (entry) begin
			cur_addr   <= first_addr[word_w-1:2];
			base_value <= req.increment ? req.base + span : req.base - span;
			increment  <= req.increment;
		end else if (advance) begin
			cur_addr <= increment ? cur_addr + 1'b1 : cur_addr - 1'b1; // One word on.
		end
	end

endmodule

// ==== design/ldst_sequencer.sv ====
`timescale 1ns/1ps

module ldst_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  ldst_pkg::reg_list   regs,
	input  logic                last_transfer,
	output ldst_pkg::ctrl_cycle cycle,
	output ldst_pkg::ctrl_cycle next_cycle,
	output logic                busy
);
	import ldst_pkg::*;

	// ==============================
	// Next state
	// ==============================
	always_comb begin
		next_cycle = cycle;
		unique case (cycle)
			ISSUE: begin
				if (issue && |regs)
					next_cycle = TRANSFER; // Empty list stays idle.
			end
			TRANSFER: begin
				if (last_transfer)
					next_cycle = ISSUE;
			end
			default: next_cycle = ISSUE;
		endcase
	end

	// ==============================
	// State register
	// ==============================
	always_ff @(posedge clk) begin
		if (rst)
			cycle <= ISSUE;
		else
			cycle <= next_cycle;
	end

	assign busy = cycle == TRANSFER;

endmodule

// ==== ldst/ldst_control.sv ====
`timescale 1ns/1ps

module ldst_control (
	input  logic                clk,
	input  logic                rst,
	input  logic                issue,
	input  ldst_pkg::ldst_req_t req,
	input  ldst_pkg::ctrl_cycle cycle,
	input  ldst_pkg::ctrl_cycle next_cycle,
	input  ldst_pkg::ptr        cur_addr,
	input  ldst_pkg::word       base_value,
	input  ldst_pkg::word       rd_value,
	input  logic                mem_ready,
	input  ldst_pkg::word       mem_rdata,
	output logic                mem_start,
	output ldst_pkg::mem_req_t  mem_req,
	output logic                advance,
	output logic                last_transfer,
	output logic                load_we,
	output ldst_pkg::load_wr_t  load_wr,
	output logic                base_we,
	output ldst_pkg::word       base_value_out
);
	import ldst_pkg::*;

	logic    accept;
	logic    ldst_load;
	logic    ldst_increment;
	logic    ldst_writeback;
	logic    pop_valid;
	reg_num  pop_lower;
	reg_num  pop_upper;
	reg_num  popped;
	reg_list mem_regs;
	reg_list next_lower;
	reg_list next_upper;
	reg_list next_regs;

	ldst_pop u_pop (
		.regs       (mem_regs),
		.valid      (pop_valid),
		.pop_lower  (pop_lower),
		.pop_upper  (pop_upper),
		.next_lower (next_lower),
		.next_upper (next_upper)
	);

	// ==============================
	// Register selection
	// ==============================
	assign accept        = issue && cycle == ISSUE && next_cycle == TRANSFER;
	assign popped        = ldst_increment ? pop_lower : pop_upper;
	assign next_regs     = ldst_increment ? next_lower : next_upper;
	assign advance       = mem_start && mem_ready && pop_valid; // Transfer completes.
	assign last_transfer = advance && next_regs == '0;

	always_comb begin
		mem_req.addr    = cur_addr;
		mem_req.write   = !ldst_load;
		mem_req.data    = rd_value; // Register file answers reg_sel.
		mem_req.reg_sel = popped;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ldst_load      <= req.load;
			ldst_increment <= req.increment;
			ldst_writeback <= req.writeback;
			mem_regs       <= req.regs;
		end else if (advance) begin
			mem_regs <= next_regs; // Drop the finished register.
		end
	end

	// ==============================
	// Strobes
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_start <= 1'b0;
			load_we   <= 1'b0;
			base_we   <= 1'b0;
		end else begin
			if (accept)
				mem_start <= 1'b1;
			else if (last_transfer)
				mem_start <= 1'b0;

			load_we <= advance && ldst_load;
			base_we <= last_transfer && ldst_writeback;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			load_wr.dst   <= popped;
			load_wr.value <= mem_rdata;
		end
		if (last_transfer)
			base_value_out <= base_value;
	end

endmodule

// ==== ldst/ldst_pop.sv ====
`timescale 1ns/1ps

module ldst_pop (
	input  ldst_pkg::reg_list regs,
	output logic              valid,
	output ldst_pkg::reg_num  pop_lower,
	output ldst_pkg::reg_num  pop_upper,
	output ldst_pkg::reg_list next_lower,
	output ldst_pkg::reg_list next_upper
);
	import ldst_pkg::*;

	assign valid = |regs;

	// Scan from the top so the lowest set bit is written last.
	always_comb begin
		pop_lower = '0;
		for (int i = num_regs - 1; i >= 0; i--) begin
			if (regs[i])
				pop_lower = reg_num'(i);
		end
	end

	// Scan from the bottom so the highest set bit wins.
	always_comb begin
		pop_upper = '0;
		for (int i = 0; i < num_regs; i++) begin
			if (regs[i])
				pop_upper = reg_num'(i);
		end
	end

	always_comb begin
		next_lower = regs;
		next_upper = regs;
		next_lower[pop_lower] = 1'b0;
		next_upper[pop_upper] = 1'b0;
	end

endmodule

// ==== common/ldst_pkg.sv ====
package ldst_pkg;

	// ==============================
	// Widths and sizes
	// ==============================
	localparam int word_w    = 32;
	localparam int ptr_w     = 30;
	localparam int num_regs  = 16;
	localparam int reg_num_w = $clog2(num_regs);
	localparam int count_w   = $clog2(num_regs + 1); // Holds 0..16.

	// ==============================
	// Basic types
	// ==============================
	typedef logic [word_w-1:0]    word;
	typedef logic [ptr_w-1:0]     ptr;
	typedef logic [reg_num_w-1:0] reg_num;
	typedef logic [num_regs-1:0]  reg_list;
	typedef logic [count_w-1:0]   reg_count;

	localparam word word_bytes = 32'd4; // Bytes per transfer.

	typedef enum logic {
		ISSUE,    // Idle, accepting a request.
		TRANSFER  // Memory transfers in progress.
	} ctrl_cycle;

	// ==============================
	// Bundles
	// ==============================
	typedef struct packed {
		word     base;
		reg_list regs;
		logic    load;
		logic    increment;
		logic    pre_indexed;
		logic    writeback;
	} ldst_req_t;

	typedef struct packed {
		ptr     addr;
		logic   write;
		word    data;
		reg_num reg_sel;
	} mem_req_t;

	typedef struct packed {
		reg_num dst;
		word    value;
	} load_wr_t;

endpackage
